// File: verilog.f
+incdir+bench
hw/isaPkg.sv
hw/corePkg.sv
hw/aluUnit.sv
hw/regFile.sv
hw/opQueue.sv
hw/instrDecoder.sv
hw/executeUnit.sv
hw/aluCore.sv
bench/aluCoreTb.sv

// File: run.sh
#!/bin/sh
# build the aluCore testbench with Verilator, run it, and judge the run from its log
rm -rf obj_dir build.log sim.log &&
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module aluCoreTb \
		-f verilog.f -o simAluCore > build.log 2>&1 &&
	./obj_dir/simAluCore > sim.log 2>&1 ||
	echo "build or simulation stopped with an error, see build.log and sim.log"
grep -q "RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: bench/refModel.svh
// reference model for the execution core testbench
// model register array, instruction encoders, expected write-back results
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// register state as the core should hold it
dataWord modelRegs [32];

function automatic void clearModel();
	for (int i = 0; i < 32; i++) begin
		modelRegs[i] = '0;
	end
endfunction

function automatic instrWord encodeR(logic [5:0] funct, regAddr rd, regAddr rs, regAddr rt);
	return {OpRType, rs, rt, rd, 5'd0, funct};
endfunction

function automatic instrWord encodeI(logic [5:0] opcode, regAddr rt, regAddr rs,
		logic [15:0] imm);
	return {opcode, rs, rt, imm};
endfunction

// expected write-back for one instruction, updates the model registers;
// returns 0 when the instruction leaves no result
function automatic bit predict(instrWord w, output wbResult expected);
	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [15:0] imm;
	dataWord     a;
	dataWord     b;
	dataWord     immSx;
	dataWord     immZx;
	dataWord     value;
	regAddr      dest;
	bit          known;

	opcode = w[31:26];
	funct  = w[5:0];
	imm    = w[15:0];
	a      = modelRegs[w[25:21]];
	b      = modelRegs[w[20:16]];
	immSx  = {{16{imm[15]}}, imm};
	immZx  = {16'h0000, imm};
	dest   = w[20:16];
	value  = '0;
	known  = 1'b1;
	case (opcode)
		OpRType: begin
			dest = w[15:11];
			case (funct)
				FnAddu:  value = a + b;
				FnSubu:  value = a - b;
				FnAnd:   value = a & b;
				FnOr:    value = a | b;
				FnXor:   value = a ^ b;
				FnNor:   value = ~(a | b);
				FnSlt:   value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				FnSltu:  value = (a < b) ? 32'd1 : 32'd0;
				default: known = 1'b0;
			endcase
		end
		// arithmetic and compares sign-extend, logic ops zero-extend
		OpAddiu: value = a + immSx;
		OpSlti:  value = ($signed(a) < $signed(immSx)) ? 32'd1 : 32'd0;
		OpSltiu: value = (a < immSx) ? 32'd1 : 32'd0;
		OpAndi:  value = a & immZx;
		OpOri:   value = a | immZx;
		OpXori:  value = a ^ immZx;
		OpLui:   value = {imm, 16'h0000};
		default: known = 1'b0;
	endcase
	expected.dest  = dest;
	expected.value = value;
	if (!known || dest == '0) begin
		return 1'b0;
	end
	modelRegs[dest] = value;
	return 1'b1;
endfunction

`endif

// File: bench/aluCoreTb.sv
// testbench for the streaming ALU core
// clock, reset, DUT, directed test tasks, result checking and watchdog
module aluCoreTb
	import isaPkg::*, corePkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	// 207 instructions over all tests, 8 cycles each, with margin
	localparam int MaxCycles = 4000;

	logic     clk = 1'b0;
	logic     reset;
	logic     instrValid;
	instrWord instr;
	logic     instrReady;
	logic     resultValid;
	wbResult  result;
	logic     resultReady;

	int       seed;
	int       errors;
	int       checks;
	int       testChecks0;
	int       testErrors0;
	int       cycleCount;
	bit       driving;
	bit       sawStall;
	instrWord progQ[$];
	wbResult  expQ[$];

	`include "refModel.svh"

	always #4 clk = ~clk;

	aluCore #(
		.QueueDepth (4)
	) aluCore_inst (
		.clk         (clk),
		.reset       (reset),
		.instrValid  (instrValid),
		.instr       (instr),
		.instrReady  (instrReady),
		.resultValid (resultValid),
		.result      (result),
		.resultReady (resultReady)
	);

	// ========================================================================
	// driving and checking
	task automatic checkResult(wbResult got, wbResult exp);
		checks++;
		if (got.dest !== exp.dest) begin
			$display("** Error at %0t ns: result.dest is %0d, expected %0d",
				$time, got.dest, exp.dest);
			errors++;
		end
		if (got.value !== exp.value) begin
			$display("** Error at %0t ns: result.value is %h, expected %h",
				$time, got.value, exp.value);
			errors++;
		end
	endtask

	task automatic sendInstr(instrWord w);
		wbResult expected;
		@(negedge clk);
		instr      = w;
		instrValid = 1'b1;
		while (!instrReady) begin
			@(negedge clk);
		end
		// transfer on the coming rising edge
		if (predict(w, expected)) begin
			expQ.push_back(expected);
		end
	endtask

	task automatic collectResults(bit randomReady);
		wbResult exp;
		int      quiet;
		quiet = 0;
		while (quiet < 8) begin
			@(negedge clk);
			if (randomReady) begin
				resultReady = ($random(seed) & 3) == 0;
			end else begin
				resultReady = 1'b1;
			end
			if (!instrReady) begin
				sawStall = 1'b1;
			end
			if (resultValid && resultReady) begin
				if (expQ.size() == 0) begin
					$display("unexpected result at %0t ns for register %0d", $time, result.dest);
					errors++;
				end else begin
					exp = expQ.pop_front();
					checkResult(result, exp);
				end
			end
			// a few quiet cycles catch stray results
			if (!driving && expQ.size() == 0) begin
				quiet++;
			end else begin
				quiet = 0;
			end
		end
		resultReady = 1'b1;
	endtask

	task automatic runProgram(bit randomReady);
		driving = 1'b1;
		fork
			begin
				foreach (progQ[i]) begin
					sendInstr(progQ[i]);
				end
				@(negedge clk);
				instrValid = 1'b0;
				driving    = 1'b0;
			end
			collectResults(randomReady);
		join
	endtask

	task automatic beginTest();
		testChecks0 = checks;
		testErrors0 = errors;
		progQ.delete();
	endtask

	task automatic endTest(string name);
		$display("%-12s done: %0d results checked, %0d errors", name,
			checks - testChecks0, errors - testErrors0);
	endtask

	function automatic instrWord randomInstr();
		regAddr      rs;
		regAddr      rt;
		regAddr      rd;
		logic [15:0] imm;
		int          pick;

		rs   = regAddr'($unsigned($random(seed)) % 8);
		rt   = regAddr'($unsigned($random(seed)) % 8);
		rd   = regAddr'(1 + $unsigned($random(seed)) % 15);
		imm  = 16'($random(seed));
		pick = int'($unsigned($random(seed)) % 15);
		case (pick)
			0:       return encodeR(FnAddu, rd, rs, rt);
			1:       return encodeR(FnSubu, rd, rs, rt);
			2:       return encodeR(FnAnd, rd, rs, rt);
			3:       return encodeR(FnOr, rd, rs, rt);
			4:       return encodeR(FnXor, rd, rs, rt);
			5:       return encodeR(FnNor, rd, rs, rt);
			6:       return encodeR(FnSlt, rd, rs, rt);
			7:       return encodeR(FnSltu, rd, rs, rt);
			8:       return encodeI(OpAddiu, rd, rs, imm);
			9:       return encodeI(OpSlti, rd, rs, imm);
			10:      return encodeI(OpSltiu, rd, rs, imm);
			11:      return encodeI(OpAndi, rd, rs, imm);
			12:      return encodeI(OpOri, rd, rs, imm);
			13:      return encodeI(OpXori, rd, rs, imm);
			default: return encodeI(OpLui, rd, rs, imm);
		endcase
	endfunction

	// ========================================================================
	// directed tests
	task automatic constantsAndRType();
		beginTest();
		progQ.push_back(encodeI(OpLui, 5'd1, 5'd0, 16'h8000));
		progQ.push_back(encodeI(OpOri, 5'd1, 5'd1, 16'h0001));
		progQ.push_back(encodeI(OpOri, 5'd2, 5'd0, 16'h0005));
		progQ.push_back(encodeI(OpLui, 5'd3, 5'd0, 16'h7fff));
		progQ.push_back(encodeI(OpOri, 5'd3, 5'd3, 16'hffff));
		progQ.push_back(encodeR(FnAddu, 5'd4, 5'd1, 5'd2));
		progQ.push_back(encodeR(FnSubu, 5'd5, 5'd2, 5'd1));
		progQ.push_back(encodeR(FnAnd, 5'd6, 5'd1, 5'd3));
		progQ.push_back(encodeR(FnOr, 5'd7, 5'd1, 5'd2));
		progQ.push_back(encodeR(FnXor, 5'd8, 5'd1, 5'd3));
		progQ.push_back(encodeR(FnNor, 5'd9, 5'd1, 5'd2));
		// negative against positive, signed and unsigned
		progQ.push_back(encodeR(FnSlt, 5'd10, 5'd1, 5'd2));
		progQ.push_back(encodeR(FnSltu, 5'd11, 5'd1, 5'd2));
		progQ.push_back(encodeR(FnSlt, 5'd12, 5'd2, 5'd1));
		progQ.push_back(encodeR(FnSltu, 5'd13, 5'd2, 5'd1));
		runProgram(1'b0);
		endTest("constants");
	endtask

	task automatic immExtension();
		beginTest();
		progQ.push_back(encodeI(OpAddiu, 5'd14, 5'd2, 16'hfffe));
		progQ.push_back(encodeI(OpAddiu, 5'd15, 5'd2, 16'h7fff));
		progQ.push_back(encodeI(OpSlti, 5'd16, 5'd2, 16'hffff));
		progQ.push_back(encodeI(OpSlti, 5'd17, 5'd2, 16'h0010));
		// large unsigned source against the sign-extended all-ones immediate
		progQ.push_back(encodeI(OpSltiu, 5'd18, 5'd1, 16'hffff));
		progQ.push_back(encodeI(OpSltiu, 5'd19, 5'd2, 16'h0003));
		progQ.push_back(encodeI(OpAndi, 5'd20, 5'd1, 16'hffff));
		progQ.push_back(encodeI(OpOri, 5'd21, 5'd0, 16'h8000));
		progQ.push_back(encodeI(OpXori, 5'd22, 5'd3, 16'hffff));
		progQ.push_back(encodeI(OpAndi, 5'd23, 5'd3, 16'h1234));
		runProgram(1'b0);
		endTest("immediates");
	endtask

	task automatic dependentChain();
		regAddr prev;
		regAddr next;
		beginTest();
		progQ.push_back(encodeI(OpAddiu, 5'd1, 5'd0, 16'h0003));
		prev = 5'd1;
		for (int i = 0; i < 14; i++) begin
			next = regAddr'(2 + (i % 8));
			case (i % 4)
				0:       progQ.push_back(encodeR(FnAddu, next, prev, prev));
				1:       progQ.push_back(encodeI(OpAddiu, next, prev, 16'hfff9));
				2:       progQ.push_back(encodeR(FnXor, next, prev, 5'd22));
				default: progQ.push_back(encodeR(FnSubu, next, 5'd0, prev));
			endcase
			prev = next;
		end
		runProgram(1'b0);
		endTest("chain");
	endtask

	task automatic randomStream();
		beginTest();
		sawStall = 1'b0;
		for (int i = 0; i < 160; i++) begin
			progQ.push_back(randomInstr());
		end
		runProgram(1'b1);
		if (!sawStall) begin
			$display("instrReady never dropped while results were held back");
			errors++;
		end
		endTest("random");
	endtask

	task automatic droppedOps();
		beginTest();
		progQ.push_back(32'h0000_0000);
		progQ.push_back(encodeI(6'h23, 5'd4, 5'd1, 16'h0010));
		progQ.push_back(encodeR(6'h08, 5'd4, 5'd1, 5'd0));
		progQ.push_back(encodeR(FnAddu, 5'd0, 5'd1, 5'd2));
		progQ.push_back(encodeI(OpOri, 5'd0, 5'd2, 16'h00ff));
		// $0 must still read zero
		progQ.push_back(encodeR(FnOr, 5'd24, 5'd0, 5'd0));
		progQ.push_back(encodeR(FnAddu, 5'd25, 5'd0, 5'd2));
		runProgram(1'b0);
		if (checks - testChecks0 != 2) begin
			$display("no-op test saw %0d results instead of 2", checks - testChecks0);
			errors++;
		end
		endTest("no-ops");
	endtask

	// ========================================================================
	// watchdog
	initial begin
		cycleCount = 0;
		while (cycleCount < MaxCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d cycles, %0d expected results never arrived",
			MaxCycles, expQ.size());
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		seed        = 94256;
		reset       = 1'b1;
		instrValid  = 1'b0;
		instr       = '0;
		resultReady = 1'b1;
		driving     = 1'b0;
		sawStall    = 1'b0;
		errors      = 0;
		checks      = 0;
		clearModel();
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		if (!instrReady || resultValid) begin
			$display("core is not idle after reset");
			errors++;
		end
		constantsAndRType();
		immExtension();
		dependentChain();
		randomStream();
		droppedOps();
		$display("summary: %0d results checked, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: hw/aluCore.sv
// streaming integer execution core, top level
// decoder -> operation queue -> execute unit
module aluCore
	import isaPkg::*, corePkg::*;
#(
	parameter int QueueDepth = 4
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     instrValid,
	input  instrWord instr,
	output logic     instrReady,
	output logic     resultValid,
	output wbResult  result,
	input  logic     resultReady
);

	logic     decValid;
	decodedOp decOp;
	logic     decReady;
	logic     qValid;
	decodedOp qOp;
	logic     qReady;

	instrDecoder instrDecoder_inst (
		.clk        (clk),
		.reset      (reset),
		.instrValid (instrValid),
		.instr      (instr),
		.instrReady (instrReady),
		.decValid   (decValid),
		.decOp      (decOp),
		.decReady   (decReady)
	);

	opQueue #(
		.itemType (decodedOp),
		.Depth    (QueueDepth)
	) opQueue_inst (
		.clk      (clk),
		.reset    (reset),
		.inValid  (decValid),
		.inItem   (decOp),
		.inReady  (decReady),
		.outValid (qValid),
		.outItem  (qOp),
		.outReady (qReady)
	);

	executeUnit executeUnit_inst (
		.clk         (clk),
		.reset       (reset),
		.qValid      (qValid),
		.qOp         (qOp),
		.qReady      (qReady),
		.resultValid (resultValid),
		.result      (result),
		.resultReady (resultReady)
	);

endmodule

// File: hw/executeUnit.sv
// execute stage
// operand read, immediate select, ALU and the result output register;
// the register file is written when a result leaves the core
module executeUnit
	import corePkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     qValid,
	input  decodedOp qOp,
	output logic     qReady,
	output logic     resultValid,
	output wbResult  result,
	input  logic     resultReady
);

	dataWord readDataA;
	dataWord readDataB;
	dataWord operandB;
	dataWord aluY;
	logic    take;
	logic    retire;

	assign qReady = !resultValid || resultReady;
	assign take   = qValid && qReady;
	assign retire = resultValid && resultReady;

	// =========================================================================
	// operands and ALU
	regFile regFile_inst (
		.clk       (clk),
		.reset     (reset),
		.writeEn   (retire),
		.writeAddr (result.dest),
		.writeData (result.value),
		.readAddrA (qOp.srcA),
		.readAddrB (qOp.srcB),
		.readDataA (readDataA),
		.readDataB (readDataB)
	);

	assign operandB = qOp.useImm ? qOp.imm : readDataB;

	aluUnit aluUnit_inst (
		.op (qOp.op),
		.a  (readDataA),
		.b  (operandB),
		.y  (aluY)
	);

	// =========================================================================
	// result register
	always_ff @(posedge clk) begin
		if (reset) begin
			resultValid <= 1'b0;
		end else if (take) begin
			resultValid <= 1'b1;
		end else if (resultReady) begin
			resultValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			result.dest  <= qOp.dest;
			result.value <= aluY;
		end
	end

endmodule

// File: hw/instrDecoder.sv
// decode stage
// maps instruction words onto decoded operations and registers them
// behind a valid/ready output stage
module instrDecoder
	import isaPkg::*, corePkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     instrValid,
	input  instrWord instr,
	output logic     instrReady,
	output logic     decValid,
	output decodedOp decOp,
	input  logic     decReady
);

	decodedOp nextOp;
	dataWord  immSigned;
	dataWord  immZero;
	logic     opOk;
	logic     keep;
	logic     accept;

	assign immSigned = {{16{instr.low.imm16[15]}}, instr.low.imm16};
	assign immZero   = {16'h0000, instr.low.imm16};

	// =========================================================================
	// opcode / funct decode
	always_comb begin
		nextOp        = '0;
		nextOp.srcA   = instr.rs;
		nextOp.srcB   = instr.rt;
		nextOp.dest   = instr.rt;
		nextOp.useImm = 1'b1;
		nextOp.imm    = immZero;
		opOk          = 1'b1;
		case (instr.opcode)
			OpRType: begin
				nextOp.dest   = instr.low.r.rd;
				nextOp.useImm = 1'b0;
				case (instr.low.r.funct)
					FnAddu:  nextOp.op = Add;
					FnSubu:  nextOp.op = Sub;
					FnAnd:   nextOp.op = And;
					FnOr:    nextOp.op = Or;
					FnXor:   nextOp.op = Xor;
					FnNor:   nextOp.op = Nor;
					FnSlt:   nextOp.op = Slt;
					FnSltu:  nextOp.op = Sltu;
					default: opOk = 1'b0;
				endcase
			end
			// arithmetic and compare forms take the signed immediate
			OpAddiu: begin
				nextOp.op  = Add;
				nextOp.imm = immSigned;
			end
			OpSlti: begin
				nextOp.op  = Slt;
				nextOp.imm = immSigned;
			end
			OpSltiu: begin
				nextOp.op  = Sltu;
				nextOp.imm = immSigned;
			end
			// logical forms keep the zero-extended immediate
			OpAndi:  nextOp.op = And;
			OpOri:   nextOp.op = Or;
			OpXori:  nextOp.op = Xor;
			OpLui:   nextOp.op = Lui;
			default: opOk = 1'b0;
		endcase
	end

	// nothing to do for unknown codes or writes to $0
	assign keep = opOk && (nextOp.dest != '0);

	// =========================================================================
	// output register
	assign instrReady = !decValid || decReady;
	assign accept     = instrValid && instrReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			decValid <= 1'b0;
		end else if (accept) begin
			decValid <= keep;
		end else if (decReady) begin
			decValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && keep) begin
			decOp <= nextOp;
		end
	end

	// a stalled operation must stay offered and unchanged under the queue
	assert property (@(posedge clk) disable iff (reset)
		decValid && !decReady |=> decValid && $stable(decOp));

endmodule

// File: hw/opQueue.sv
// synchronous FIFO for any packed payload type
// circular buffer with read/write pointers and an item count,
// read and write allowed in the same cycle
module opQueue #(
	parameter type itemType = logic [7:0],
	parameter int  Depth    = 4
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    inValid,
	input  itemType inItem,
	output logic    inReady,
	output logic    outValid,
	output itemType outItem,
	input  logic    outReady
);

	localparam int PtrWidth = $clog2(Depth);

	itemType             mem [Depth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [PtrWidth:0]   count;
	logic                wrEn;
	logic                rdEn;

	assign inReady  = (count != Depth[PtrWidth:0]);
	assign outValid = (count != '0);
	assign outItem  = mem[rdPtr];

	assign wrEn = inValid && inReady;
	assign rdEn = outValid && outReady;

	// storage
	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrPtr] <= inItem;
		end
	end

	// pointers wrap on their own since Depth is a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (wrEn) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (rdEn) begin
				rdPtr <= rdPtr + 1'b1;
			end
			if (wrEn && !rdEn) begin
				count <= count + 1'b1;
			end else if (rdEn && !wrEn) begin
				count <= count - 1'b1;
			end
		end
	end

	// a full queue never grows and an empty one never wraps below zero
	assert property (@(posedge clk) disable iff (reset)
		count == Depth[PtrWidth:0] |=> count <= Depth[PtrWidth:0]);
	assert property (@(posedge clk) disable iff (reset)
		count == '0 |=> count <= 1);

endmodule

// File: hw/regFile.sv
// 32-entry register file, two read ports and one write port
// write-through bypass from the write port to both read ports
module regFile
	import corePkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    writeEn,
	input  regAddr  writeAddr,
	input  dataWord writeData,
	input  regAddr  readAddrA,
	input  regAddr  readAddrB,
	output dataWord readDataA,
	output dataWord readDataB
);

	dataWord regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// a read of the register being written sees the new value
	assign readDataA = (readAddrA == '0) ? '0 :
		(writeEn && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 :
		(writeEn && writeAddr == readAddrB) ? writeData : regs[readAddrB];

	// decode drops $0 destinations well upstream of here
	assert property (@(posedge clk) disable iff (reset)
		writeEn |-> writeAddr != '0);

endmodule

// File: hw/aluUnit.sv
// combinational integer ALU
// logic, add/sub, signed and unsigned set-less-than, lui
module aluUnit
	import corePkg::*;
(
	input  aluOp    op,
	input  dataWord a,
	input  dataWord b,
	output dataWord y
);

	logic lessSigned;
	logic lessUnsigned;

	assign lessSigned   = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb begin
		case (op)
			And:     y = a & b;
			Or:      y = a | b;
			Add:     y = a + b;
			Sub:     y = a - b;
			Nor:     y = ~(a | b);
			Xor:     y = a ^ b;
			Slt:     y = {{(DataWidth-1){1'b0}}, lessSigned};
			Sltu:    y = {{(DataWidth-1){1'b0}}, lessUnsigned};
			// low half of b moves to the upper half
			Lui:     y = {b[15:0], 16'h0000};
			default: y = '0;
		endcase
	end

endmodule

// File: hw/corePkg.sv
// execution core definitions
// datapath widths, ALU operation codes
// decoded operation and write-back result structs
package corePkg;

	localparam int DataWidth    = 32;
	localparam int RegAddrWidth = 5;

	typedef logic [RegAddrWidth-1:0] regAddr;
	typedef logic [DataWidth-1:0]    dataWord;

	// same encoding as the classic pipeline ALU
	typedef enum logic [3:0] {
		And  = 4'h0,
		Or   = 4'h1,
		Add  = 4'h2,
		Sub  = 4'h3,
		Nor  = 4'h4,
		Slt  = 4'h5,
		Xor  = 4'h6,
		Sltu = 4'h7,
		Lui  = 4'h8
	} aluOp;

	// one queued operation, immediate already extended
	// padded out to a whole number of bytes
	typedef struct packed {
		aluOp       op;
		regAddr     srcA;
		regAddr     srcB;
		regAddr     dest;
		logic       useImm;
		dataWord    imm;
		logic [3:0] spare;
	} decodedOp;

	// register write offered on the result port
	typedef struct packed {
		regAddr  dest;
		dataWord value;
	} wbResult;

endpackage

// File: hw/isaPkg.sv
// MIPS instruction set definitions
// opcode and funct constants for the supported integer operations
// packed instruction word layout
package isaPkg;

	// major opcodes
	localparam logic [5:0] OpRType = 6'h00;
	localparam logic [5:0] OpAddiu = 6'h09;
	localparam logic [5:0] OpSlti  = 6'h0a;
	localparam logic [5:0] OpSltiu = 6'h0b;
	localparam logic [5:0] OpAndi  = 6'h0c;
	localparam logic [5:0] OpOri   = 6'h0d;
	localparam logic [5:0] OpXori  = 6'h0e;
	localparam logic [5:0] OpLui   = 6'h0f;

	// funct field of R-type words
	localparam logic [5:0] FnAddu = 6'h21;
	localparam logic [5:0] FnSubu = 6'h23;
	localparam logic [5:0] FnAnd  = 6'h24;
	localparam logic [5:0] FnOr   = 6'h25;
	localparam logic [5:0] FnXor  = 6'h26;
	localparam logic [5:0] FnNor  = 6'h27;
	localparam logic [5:0] FnSlt  = 6'h2a;
	localparam logic [5:0] FnSltu = 6'h2b;

	// low half, either rd/shamt/funct or the 16-bit immediate
	typedef struct packed {
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields;

	typedef union packed {
		rFields      r;
		logic [15:0] imm16;
	} lowHalf;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		lowHalf     low;
	} instrWord;

endpackage
